// ==== list.f ====
rtl/ps2_kbd_pkg.sv
rtl/ps2_rx_frame.sv
rtl/ps2_scan_xlate.sv
rtl/ps2_scan_fifo.sv
rtl/ps2_kbd_wb.sv
rtl/ps2_kbd_top.sv
testbench/ps2_kbd_props.sv
testbench/tb_ps2_kbd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PS/2 keyboard controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ps2_kbd -f list.f -o tb_ps2_kbd
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_ps2_kbd 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "PASS: all tests"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/tb_ps2_kbd.sv ====
// ---------------------------------------------------------------------------
// Testbench for the PS/2 keyboard controller
// Drives PS/2 frames, reads codes and status over Wishbone and compares
// them with a scan-code model kept in the testbench
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_kbd;

  import ps2_kbd_pkg::*;

  localparam int FILTER_CYCLES  = 4;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int FIFO_DEPTH     = 8;
  localparam int HALF_BIT       = 20;
  localparam int FRAME_GAP      = 20;
  localparam int NUM_FRAMES     = 42;
  localparam int MARGIN_CYCLES  = 4000;
  localparam int BUS_TIMEOUT    = 16;
  localparam int IRQ_WAIT       = 64;

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic       wb_adr;
  logic [7:0] wb_wdata;
  logic [7:0] wb_rdata;
  logic       wb_ack;
  logic       irq;

  // Set 2 make codes and their set 1 values, last entry has no translation
  logic [7:0] set2_codes [16] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33,
                                  8'h16, 8'h1E, 8'h29, 8'h5A, 8'h66, 8'h76, 8'h05, 8'h00};
  logic [7:0] set1_codes [16] = '{8'h1E, 8'h30, 8'h2E, 8'h20, 8'h12, 8'h21, 8'h22, 8'h23,
                                  8'h02, 8'h03, 8'h39, 8'h1C, 8'h0E, 8'h01, 8'h3B, 8'h00};

  // Model state
  logic [7:0]  exp_q [$];
  logic        model_release;
  logic        exp_overrun;
  logic        exp_ferr;
  logic [31:0] lcg_state;

  ps2_kbd_top #(
    .FILTER_CYCLES  (FILTER_CYCLES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .FIFO_DEPTH     (FIFO_DEPTH)
  ) i_ps2_kbd_top (
    .clk      (clk),
    .reset    (reset),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .irq      (irq)
  );

  bind ps2_kbd_wb ps2_kbd_props i_ps2_kbd_props (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we  (wb_we),
    .wb_adr (wb_adr),
    .wb_ack (wb_ack),
    .irq    (irq)
  );

  // 250 MHz system clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %02h, actual %02h", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] lookup_set1(input logic [7:0] c);
    logic [7:0] res;
    res = 8'h00;
    for (int i = 0; i < 16; i++)
      if (set2_codes[i] == c)
        res = set1_codes[i];
    return res;
  endfunction

  // Start bit first, odd parity, stop high
  function automatic logic [10:0] make_frame(input logic [7:0] c);
    return {1'b1, ~^c, c, 1'b0};
  endfunction

  // Apply the translation rule and FIFO-full dropping to one good byte
  task automatic model_frame(input logic [7:0] c);
    logic [7:0] xt;
    logic       emit;
    xt   = 8'h00;
    emit = 1'b0;
    if (c == RELEASE_PREFIX)
      model_release = 1'b1;
    else
    begin
      if (c[7])
      begin
        xt   = c;
        emit = 1'b1;
      end
      else
      begin
        xt    = lookup_set1(c);
        emit  = (xt != 8'h00);
        xt[7] = model_release;
      end
      model_release = 1'b0;
      if (emit && exp_q.size() < FIFO_DEPTH)
        exp_q.push_back(xt);
      else if (emit)
        exp_overrun = 1'b1;
    end
  endtask

  // Data changes while the PS/2 clock is high, device samples on the fall
  task automatic send_bits(input logic [10:0] bits, input int nbits);
    for (int i = 0; i < nbits; i++)
    begin
      @(posedge clk);
      ps2_data <= bits[i];
      repeat (HALF_BIT / 2) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b1;
      repeat (HALF_BIT / 2) @(posedge clk);
    end
    @(posedge clk);
    ps2_data <= 1'b1;
    repeat (FRAME_GAP) @(posedge clk);
  endtask

  // irq rising marks the end of a frame that queued a code
  task automatic check_irq(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && !irq && waited < IRQ_WAIT)
    begin
      waited++;
      @(negedge clk);
    end
    check_value(name, {7'b0, exp_q.size() != 0}, {7'b0, irq});
  endtask

  task automatic send_code(input logic [7:0] c);
    send_bits(make_frame(c), 11);
    model_frame(c);
    check_irq("irq after frame");
  endtask

  // One Wishbone classic cycle, outputs sampled on the falling edge
  task automatic bus_access(input logic we, input logic adr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_wdata <= wdata;
    @(negedge clk);
    while (!wb_ack)
    begin
      waited++;
      if (waited > BUS_TIMEOUT)
      begin
        $display("[ERROR] Wishbone slave never raised wb_ack");
        abort_run();
      end
      @(negedge clk);
    end
    rdata = wb_rdata;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic read_data(input string name);
    logic [7:0] d;
    logic [7:0] exp;
    exp = (exp_q.size() != 0) ? exp_q.pop_front() : 8'h00;
    bus_access(1'b0, ADR_DATA, 8'h00, d);
    check_value(name, exp, d);
  endtask

  task automatic read_status(input string name);
    logic [7:0] d;
    logic [7:0] exp;
    exp                 = 8'h00;
    exp[STAT_OBF]       = (exp_q.size() != 0);
    exp[STAT_OVERRUN]   = exp_overrun;
    exp[STAT_FRAME_ERR] = exp_ferr;
    bus_access(1'b0, ADR_STATUS, 8'h00, d);
    check_value(name, exp, d);
    exp_overrun = 1'b0;
    exp_ferr    = 1'b0;
  endtask

  task automatic drain(input string name);
    while (exp_q.size() != 0)
      read_data(name);
    check_irq("irq after drain");
  endtask

  // ---------------------------------------------------------------------------
  // Watchdog, 40 cycles per PS/2 bit plus margin
  // ---------------------------------------------------------------------------
  initial
  begin
    repeat (NUM_FRAMES * FRAME_BITS * 40 + MARGIN_CYCLES) @(posedge clk);
    $display("[ERROR] Watchdog expired before the tests finished");
    abort_run();
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    logic [7:0]  d;
    logic [10:0] bad;
    reset         <= 1'b1;
    ps2_clk       <= 1'b1;
    ps2_data      <= 1'b1;
    wb_cyc        <= 1'b0;
    wb_stb        <= 1'b0;
    wb_we         <= 1'b0;
    wb_adr        <= 1'b0;
    wb_wdata      <= 8'h00;
    model_release = 1'b0;
    exp_overrun   = 1'b0;
    exp_ferr      = 1'b0;
    lcg_state     = 32'hafa3_a7bc;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Random make codes, unmapped 00 included
    for (int r = 0; r < 5; r++)
    begin
      for (int k = 0; k < 4; k++)
        send_code(set2_codes[rand_next() >> 28]);
      drain("make codes");
    end

    // Unmapped code on its own leaves irq low
    send_code(8'h00);

    // Release prefix sets bit 7 on the next code only
    send_code(8'hF0);
    send_code(8'h1C);
    send_code(8'h1C);
    drain("release prefix");

    // Extended prefixes pass through
    send_code(8'hE0);
    send_code(8'h1C);
    send_code(8'hE1);
    drain("high codes");

    // Bad parity, then bad stop bit
    bad = make_frame(8'h1C) ^ 11'h200;
    send_bits(bad, 11);
    exp_ferr = 1'b1;
    read_status("parity error status");
    read_status("parity error cleared");
    bad = make_frame(8'h32) & 11'h3FF;
    send_bits(bad, 11);
    exp_ferr = 1'b1;
    read_status("stop error status");
    read_status("stop error cleared");
    check_irq("irq after bad frames");

    // Overrun with ten mapped codes, a write in between has no effect
    for (int k = 0; k < 10; k++)
      send_code(set2_codes[(rand_next() >> 16) % 15]);
    bus_access(1'b1, ADR_DATA, 8'h5A, d);
    read_status("overrun status");
    for (int k = 0; k < FIFO_DEPTH; k++)
      read_data("overrun readback");
    read_data("empty read");
    check_irq("irq when empty");
    read_status("overrun cleared");

    // Truncated frame is dropped by the receiver watchdog
    send_bits(make_frame(8'h24), 5);
    repeat (TIMEOUT_CYCLES + 50) @(posedge clk);
    send_code(8'h1C);
    read_status("after truncated frame");
    drain("after truncated frame");

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/ps2_kbd_props.sv ====
// ---------------------------------------------------------------------------
// Assertions for the keyboard controller bus port
// Wishbone ack timing and interrupt release
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_props (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic wb_adr,
  input logic wb_ack,
  input logic irq
);

  import ps2_kbd_pkg::*;

  // Ack answers a request seen in the cycle before
  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without cyc and stb in the previous cycle");

  // Single-cycle ack
  ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles in a row");

  // Interrupt drops only after a data port read took the last code
  irq_fall_on_read: assert property (@(posedge clk) disable iff (reset)
    $fell(irq) |->
      $past(wb_cyc && wb_stb && !wb_ack && !wb_we && (wb_adr == ADR_DATA)))
    else $error("irq fell without a data port read");

endmodule

`default_nettype wire

// ==== rtl/ps2_kbd_top.sv ====
// ---------------------------------------------------------------------------
// PS/2 keyboard controller top level
// Receive-only 8042 subset, frame receiver to translator to FIFO to bus
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_top #(
  parameter int FILTER_CYCLES  = 8,
  parameter int TIMEOUT_CYCLES = 1920,
  parameter int FIFO_DEPTH     = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic       wb_adr,
  input  logic [7:0] wb_wdata,
  output logic [7:0] wb_rdata,
  output logic       wb_ack,
  output logic       irq
);

  import ps2_kbd_pkg::*;

  // Receiver outputs
  logic       frame_valid;
  logic       frame_error;
  scan_code_t frame_code;
  // Translator outputs
  logic       code_valid;
  scan_code_t code;
  // FIFO side
  scan_code_t head;
  logic       empty;
  logic       overflow;
  logic       pop;

  ps2_rx_frame #(
    .FILTER_CYCLES  (FILTER_CYCLES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_ps2_rx_frame (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .frame_valid (frame_valid),
    .frame_code  (frame_code),
    .frame_error (frame_error)
  );

  ps2_scan_xlate i_ps2_scan_xlate (
    .clk         (clk),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame_code  (frame_code),
    .code_valid  (code_valid),
    .code        (code)
  );

  ps2_scan_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_ps2_scan_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (code_valid),
    .push_data (code),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .overflow  (overflow)
  );

  ps2_kbd_wb i_ps2_kbd_wb (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_wdata    (wb_wdata),
    .wb_rdata    (wb_rdata),
    .wb_ack      (wb_ack),
    .head        (head),
    .empty       (empty),
    .overflow    (overflow),
    .frame_error (frame_error),
    .pop         (pop),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// ==== rtl/ps2_kbd_wb.sv ====
// ---------------------------------------------------------------------------
// Wishbone classic slave for the keyboard controller
// Data port pops the FIFO, status port reports and clears sticky errors
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_wb (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic                    wb_adr,
  input  logic [7:0]              wb_wdata,
  output logic [7:0]              wb_rdata,
  output logic                    wb_ack,
  input  ps2_kbd_pkg::scan_code_t head,
  input  logic                    empty,
  input  logic                    overflow,
  input  logic                    frame_error,
  output logic                    pop,
  output logic                    irq
);

  import ps2_kbd_pkg::*;

  logic       bus_req;
  logic       rd_data;
  logic       rd_status;
  logic       overrun_q;
  logic       frame_err_q;
  logic [7:0] status_word;

  // No new request while the previous ack is out
  assign bus_req   = wb_cyc && wb_stb && !wb_ack;
  assign rd_data   = bus_req && !wb_we && (wb_adr == ADR_DATA);
  assign rd_status = bus_req && !wb_we && (wb_adr == ADR_STATUS);
  assign pop       = rd_data && !empty;
  assign irq       = !empty;

  always_comb
  begin
    status_word                 = '0;
    status_word[STAT_OBF]       = !empty;
    status_word[STAT_OVERRUN]   = overrun_q;
    status_word[STAT_FRAME_ERR] = frame_err_q;
  end

  // ---------------------------------------------------------------------------
  // Handshake and sticky status
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_ack      <= 1'b0;
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end
    else
    begin
      wb_ack <= bus_req;
      // A new event wins over a clear in the same cycle
      overrun_q   <= overflow || (overrun_q && !rd_status);
      frame_err_q <= frame_error || (frame_err_q && !rd_status);
    end
  end

  // Read data, empty FIFO reads back as zero
  always_ff @(posedge clk)
  begin
    if (rd_data)
      wb_rdata <= empty ? 8'h00 : head;
    else if (rd_status)
      wb_rdata <= status_word;
  end

endmodule

`default_nettype wire

// ==== rtl/ps2_scan_fifo.sv ====
// ---------------------------------------------------------------------------
// Scan-code FIFO
// Circular buffer of translated codes, drops a push when full and flags
// the loss with a one-cycle overflow pulse
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_scan_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push,
  input  ps2_kbd_pkg::scan_code_t push_data,
  input  logic                    pop,
  output ps2_kbd_pkg::scan_code_t head,
  output logic                    empty,
  output logic                    overflow
);

  import ps2_kbd_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  scan_code_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;
  assign head    = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap naturally with a power-of-two depth
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      count    <= count + (push_ok ? 1'b1 : 1'b0) - (pop_ok ? 1'b1 : 1'b0);
      overflow <= push && full;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ps2_scan_xlate.sv ====
// ---------------------------------------------------------------------------
// Scan-code translator
// Converts AT set 2 codes to XT set 1, folds the F0 release prefix into
// bit 7 and passes codes at or above 80 through unchanged
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_scan_xlate (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    frame_valid,
  input  ps2_kbd_pkg::scan_code_t frame_code,
  output logic                    code_valid,
  output ps2_kbd_pkg::scan_code_t code
);

  import ps2_kbd_pkg::*;

  // Set 2 to set 1, indexed by the low seven bits
  // Zero marks a code with no translation
  localparam scan_code_t XT_TABLE [0:127] = '{
    8'h00, 8'h43, 8'h00, 8'h3F, 8'h3D, 8'h3B, 8'h3C, 8'h58,
    8'h00, 8'h44, 8'h42, 8'h40, 8'h3E, 8'h0F, 8'h29, 8'h00,
    8'h00, 8'h38, 8'h2A, 8'h00, 8'h1D, 8'h10, 8'h02, 8'h00,
    8'h00, 8'h00, 8'h2C, 8'h1F, 8'h1E, 8'h11, 8'h03, 8'h00,
    8'h00, 8'h2E, 8'h2D, 8'h20, 8'h12, 8'h05, 8'h04, 8'h00,
    8'h00, 8'h39, 8'h2F, 8'h21, 8'h14, 8'h13, 8'h06, 8'h00,
    8'h00, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h00,
    8'h00, 8'h00, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h00,
    8'h00, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0B, 8'h0A, 8'h00,
    8'h00, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0C, 8'h00,
    8'h00, 8'h00, 8'h28, 8'h00, 8'h1A, 8'h0D, 8'h00, 8'h00,
    8'h3A, 8'h36, 8'h1C, 8'h1B, 8'h00, 8'h2B, 8'h00, 8'h00,
    8'h00, 8'h56, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0E, 8'h00,
    8'h00, 8'h4F, 8'h00, 8'h4B, 8'h47, 8'h00, 8'h00, 8'h00,
    8'h52, 8'h53, 8'h50, 8'h4C, 8'h4D, 8'h48, 8'h01, 8'h45,
    8'h57, 8'h4E, 8'h51, 8'h4A, 8'h37, 8'h49, 8'h46, 8'h00
  };

  logic       release_flag;
  scan_code_t xt_code;
  logic       is_prefix;

  assign xt_code   = XT_TABLE[frame_code[6:0]];
  assign is_prefix = (frame_code == RELEASE_PREFIX);

  // ---------------------------------------------------------------------------
  // Release flag and output strobe
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      release_flag <= 1'b0;
      code_valid   <= 1'b0;
    end
    else
    begin
      code_valid <= 1'b0;
      if (frame_valid)
      begin
        // Flag lives for exactly one following byte
        release_flag <= is_prefix;
        if (!is_prefix)
        begin
          if (frame_code[7])
            code_valid <= 1'b1;
          else
            code_valid <= (xt_code != '0);
        end
      end
    end
  end

  // Translated byte, high codes such as E0 and E1 go out as is
  always_ff @(posedge clk)
  begin
    if (frame_valid && !is_prefix)
    begin
      if (frame_code[7])
        code <= frame_code;
      else
        code <= {release_flag, xt_code[6:0]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ps2_rx_frame.sv ====
// ---------------------------------------------------------------------------
// PS/2 frame receiver
// Synchronizes and filters the PS/2 lines, shifts in 11-bit frames on the
// falling clock edge, checks start, parity and stop bits and drops frames
// that stall part way through
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ps2_rx_frame #(
  parameter int FILTER_CYCLES  = 8,
  parameter int TIMEOUT_CYCLES = 1920
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ps2_clk,
  input  logic                   ps2_data,
  output logic                   frame_valid,
  output ps2_kbd_pkg::scan_code_t frame_code,
  output logic                   frame_error
);

  import ps2_kbd_pkg::*;

  localparam int FILT_W = $clog2(FILTER_CYCLES + 1);
  localparam int TMO_W  = $clog2(TIMEOUT_CYCLES + 1);
  localparam int CNT_W  = $clog2(FRAME_BITS + 1);

  localparam logic [FILT_W-1:0] FILT_LAST  = FILT_W'(FILTER_CYCLES - 1);
  localparam logic [TMO_W-1:0]  TMO_LAST   = TMO_W'(TIMEOUT_CYCLES - 1);
  localparam logic [CNT_W-1:0]  CNT_FRAME  = CNT_W'(FRAME_BITS);

  logic [1:0]            clk_sync;
  logic [1:0]            data_sync;
  logic                  clk_filt;
  logic [FILT_W-1:0]     filt_cnt;
  logic [TMO_W-1:0]      tmo_cnt;
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] shreg;
  logic                  frame_ok;
  rx_state_t             state;
  rx_state_t             state_next;

  // ---------------------------------------------------------------------------
  // Input synchronizers and clock glitch filter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_filt  <= 1'b1;
      filt_cnt  <= '0;
    end
    else
    begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      // New level must hold for the full filter window
      if (clk_sync[1] == clk_filt)
        filt_cnt <= '0;
      else if (filt_cnt == FILT_LAST)
      begin
        clk_filt <= clk_sync[1];
        filt_cnt <= '0;
      end
      else
        filt_cnt <= filt_cnt + 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // Frame sequencing
  // ---------------------------------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      RX_IDLE_HIGH:   if (!clk_filt) state_next = RX_FALL_SAMPLE;
      RX_FALL_SAMPLE: state_next = RX_CLK_LOW;
      RX_CLK_LOW:
        if (clk_filt)
          state_next = (bit_cnt == CNT_FRAME) ? RX_FRAME_CHECK : RX_IDLE_HIGH;
      RX_FRAME_CHECK: state_next = RX_IDLE_HIGH;
      default:        state_next = RX_IDLE_HIGH;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= RX_IDLE_HIGH;
      bit_cnt <= '0;
      tmo_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      // Watchdog runs only with a partial frame and the clock idle high
      if (state == RX_IDLE_HIGH && bit_cnt != '0)
      begin
        if (tmo_cnt == TMO_LAST)
        begin
          tmo_cnt <= '0;
          bit_cnt <= '0;
        end
        else
          tmo_cnt <= tmo_cnt + 1'b1;
      end
      else
        tmo_cnt <= '0;
      if (state == RX_FALL_SAMPLE)
        bit_cnt <= bit_cnt + 1'b1;
      else if (state == RX_FRAME_CHECK)
        bit_cnt <= '0;
    end
  end

  // LSB first, so the start bit ends up in bit 0
  always_ff @(posedge clk)
  begin
    if (state == RX_FALL_SAMPLE)
      shreg <= {data_sync[1], shreg[FRAME_BITS-1:1]};
  end

  // Start low, stop high, odd parity over data and parity bit
  assign frame_ok = !shreg[0] && shreg[FRAME_BITS-1] && (^shreg[9:1]);

  assign frame_valid = (state == RX_FRAME_CHECK) && frame_ok;
  assign frame_error = (state == RX_FRAME_CHECK) && !frame_ok;
  assign frame_code  = shreg[8:1];

endmodule

`default_nettype wire

// ==== rtl/ps2_kbd_pkg.sv ====
// ---------------------------------------------------------------------------
// PS/2 keyboard controller shared definitions
// Scan-code type, receiver states, bus port map and status bit layout
// ---------------------------------------------------------------------------
`default_nettype none

package ps2_kbd_pkg;

  // One byte of keyboard data, set 2 raw or set 1 translated
  typedef logic [7:0] scan_code_t;

  // Receiver sequencing
  typedef enum logic [1:0] {
    RX_IDLE_HIGH,    // Clock high, waiting for a falling edge
    RX_FALL_SAMPLE,  // One cycle, data bit is shifted in
    RX_CLK_LOW,      // Clock low, waiting for the rising edge
    RX_FRAME_CHECK   // One cycle, frame is checked and reported
  } rx_state_t;

  // Bus port addresses
  localparam logic ADR_DATA   = 1'b0;
  localparam logic ADR_STATUS = 1'b1;

  // Status register bit positions
  localparam int STAT_OBF       = 0;
  localparam int STAT_OVERRUN   = 1;
  localparam int STAT_FRAME_ERR = 2;

  // Break prefix in scan-code set 2
  localparam scan_code_t RELEASE_PREFIX = 8'hF0;

  // Start, eight data, parity, stop
  localparam int FRAME_BITS = 11;

endpackage

`default_nettype wire
